// ==== logic/btLinkPkg.sv ====
package btLinkPkg;

	// phone command opcodes, first byte of each two-byte command
	typedef enum logic [7:0] {
		opSetLed       = 8'h10,
		opEcho         = 8'h20,
		opReadCmdCount = 8'h30
	} opcode_t;

	// reply for any opcode not listed above
	localparam logic [7:0] replyError = 8'hEE;

	// config values seen until the host writes the wire-ins
	localparam logic [15:0] defaultCyclesPerBit = 16'd50;
	localparam logic [7:0] defaultSpacingLimit = 8'd12;

	// uart timing below this leaves no room for mid-bit sampling
	localparam logic [15:0] minCyclesPerBit = 16'd4;

	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxState_t;
	typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txState_t;
	typedef enum logic {decWaitOp, decWaitArg} decState_t;

	// host config, registered from ep01/ep02
	typedef struct packed {
		logic [15:0] cyclesPerBit;
		logic [7:0] spacingLimit;
		logic clearCounts;
	} linkCfg_t;

	// one-cycle command report from decoder to status regs
	typedef struct packed {
		logic valid;
		logic [7:0] opcode;
		logic [7:0] arg;
		logic timeout;
		logic [1:0] reserved;
	} cmdEvent_t;

endpackage

// ==== logic/uartRx.sv ====
`timescale 1ns/1ps

module uartRx
	import btLinkPkg::*;
(
	input logic clock,
	input logic arstN,
	input logic rxd,
	input linkCfg_t cfg,
	output logic [7:0] rxByte,
	output logic rxValid
);

	// two sync flops plus one history flop for the edge
	logic [2:0] rxSync;
	logic rxBit;
	logic startEdge;
	rxState_t state;
	logic [15:0] bitCnt;
	logic [2:0] bitIdx;
	logic [7:0] shiftReg;
	logic [15:0] halfBit;
	logic bitDone;

	assign rxBit = rxSync[1];
	assign startEdge = rxSync[2] & ~rxSync[1];
	assign halfBit = {1'b0, cfg.cyclesPerBit[15:1]};
	assign bitDone = (bitCnt == cfg.cyclesPerBit - 16'd1);

	// line idles high
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			rxSync <= 3'b111;
		end else begin
			rxSync <= {rxSync[1:0], rxd};
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= rxIdle;
			bitCnt <= '0;
			bitIdx <= '0;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			case (state)
				rxIdle: begin
					bitCnt <= '0;
					if (startEdge) begin
						state <= rxStart;
					end
				end
				// wait to mid start bit, then sample centres from there
				rxStart: begin
					if (bitCnt == halfBit - 16'd1) begin
						bitCnt <= '0;
						bitIdx <= '0;
						// high again means a glitch, not a start bit
						state <= rxBit ? rxIdle : rxData;
					end else begin
						bitCnt <= bitCnt + 16'd1;
					end
				end
				rxData: begin
					if (bitDone) begin
						bitCnt <= '0;
						bitIdx <= bitIdx + 3'd1;
						if (bitIdx == 3'd7) begin
							state <= rxStop;
						end
					end else begin
						bitCnt <= bitCnt + 16'd1;
					end
				end
				rxStop: begin
					if (bitDone) begin
						// framing error drops the byte silently
						rxValid <= rxBit;
						state <= rxIdle;
					end else begin
						bitCnt <= bitCnt + 16'd1;
					end
				end
				default: begin
					state <= rxIdle;
				end
			endcase
		end
	end

	// lsb first, shifts in from the top
	always_ff @(posedge clock) begin
		if (state == rxData && bitDone) begin
			shiftReg <= {rxBit, shiftReg[7:1]};
		end
	end

	assign rxByte = shiftReg;

	// bit time must stay sane for the whole frame
	rxBitTimeOk: assert property (@(posedge clock) disable iff (!arstN)
		state != rxIdle |-> cfg.cyclesPerBit >= minCyclesPerBit);

endmodule

// ==== logic/uartTx.sv ====
`timescale 1ns/1ps

module uartTx
	import btLinkPkg::*;
(
	input logic clock,
	input logic arstN,
	input linkCfg_t cfg,
	input logic txStart,
	input logic [7:0] txByte,
	output logic txd,
	output logic txBusy
);

	txState_t state;
	logic [15:0] bitCnt;
	logic [2:0] bitIdx;
	logic [7:0] shiftReg;
	logic bitDone;

	assign bitDone = (bitCnt == cfg.cyclesPerBit - 16'd1);
	assign txBusy = (state != txIdle);

	// start state literal is shadowed by the port, hence the package prefix
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= txIdle;
			bitCnt <= '0;
			bitIdx <= '0;
			txd <= 1'b1;
		end else begin
			case (state)
				txIdle: begin
					bitCnt <= '0;
					if (txStart) begin
						txd <= 1'b0;
						state <= btLinkPkg::txStart;
					end
				end
				btLinkPkg::txStart: begin
					if (bitDone) begin
						bitCnt <= '0;
						bitIdx <= '0;
						txd <= shiftReg[0];
						state <= txData;
					end else begin
						bitCnt <= bitCnt + 16'd1;
					end
				end
				txData: begin
					if (bitDone) begin
						bitCnt <= '0;
						bitIdx <= bitIdx + 3'd1;
						// after bit 7 the stop bit goes out
						txd <= (bitIdx == 3'd7) ? 1'b1 : shiftReg[0];
						if (bitIdx == 3'd7) begin
							state <= txStop;
						end
					end else begin
						bitCnt <= bitCnt + 16'd1;
					end
				end
				txStop: begin
					if (bitDone) begin
						state <= txIdle;
					end else begin
						bitCnt <= bitCnt + 16'd1;
					end
				end
				default: begin
					state <= txIdle;
				end
			endcase
		end
	end

	// shiftReg[0] always holds the next bit to send
	always_ff @(posedge clock) begin
		if (state == txIdle && txStart) begin
			shiftReg <= txByte;
		end else if (bitDone && (state == btLinkPkg::txStart || state == txData)) begin
			shiftReg <= {1'b1, shiftReg[7:1]};
		end
	end

	txNoOverlap: assert property (@(posedge clock) disable iff (!arstN)
		txStart |-> !txBusy);

	txBitTimeOk: assert property (@(posedge clock) disable iff (!arstN)
		txBusy |-> cfg.cyclesPerBit >= minCyclesPerBit);

endmodule

// ==== logic/cmdDecoder.sv ====
`timescale 1ns/1ps

module cmdDecoder
	import btLinkPkg::*;
(
	input logic clock,
	input logic arstN,
	input linkCfg_t cfg,
	input logic btState,
	input logic [7:0] rxByte,
	input logic rxValid,
	input logic txBusy,
	input logic [15:0] cmdCount,
	output cmdEvent_t cmdEvt,
	output logic txStart,
	output logic [7:0] txByte
);

	decState_t state;
	logic [7:0] opReg;
	logic [15:0] prescale;
	logic [7:0] spacingCnt;
	logic replyPending;
	logic [7:0] replyByte;
	logic take;
	logic argDone;
	logic bitTick;
	logic [7:0] replyNext;

	// link down hides every received byte
	assign take = rxValid & btState;
	assign argDone = take && state == decWaitArg;
	assign bitTick = (prescale == cfg.cyclesPerBit - 16'd1);

	// reply rule per opcode, count read before this command lands
	always_comb begin
		case (opReg)
			opSetLed: replyNext = rxByte;
			opEcho: replyNext = rxByte;
			opReadCmdCount: replyNext = cmdCount[7:0];
			default: replyNext = replyError;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= decWaitOp;
			prescale <= '0;
			spacingCnt <= '0;
			cmdEvt <= '0;
		end else begin
			cmdEvt.valid <= 1'b0;
			cmdEvt.timeout <= 1'b0;
			cmdEvt.reserved <= 2'b00;
			case (state)
				decWaitOp: begin
					prescale <= '0;
					spacingCnt <= '0;
					if (take) begin
						state <= decWaitArg;
					end
				end
				decWaitArg: begin
					if (take) begin
						state <= decWaitOp;
						cmdEvt.valid <= 1'b1;
						cmdEvt.opcode <= opReg;
						cmdEvt.arg <= rxByte;
					end else if (bitTick) begin
						prescale <= '0;
						// one more bit time would exceed the limit
						if (spacingCnt == cfg.spacingLimit) begin
							state <= decWaitOp;
							cmdEvt.timeout <= 1'b1;
							cmdEvt.opcode <= opReg;
						end else begin
							spacingCnt <= spacingCnt + 8'd1;
						end
					end else begin
						prescale <= prescale + 16'd1;
					end
				end
				default: begin
					state <= decWaitOp;
				end
			endcase
		end
	end

	// opcode byte and reply byte are payload
	always_ff @(posedge clock) begin
		if (take && state == decWaitOp) begin
			opReg <= rxByte;
		end
		if (argDone) begin
			replyByte <= replyNext;
		end
	end

	// reply waits out a busy transmitter
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			replyPending <= 1'b0;
			txStart <= 1'b0;
		end else begin
			txStart <= 1'b0;
			if (argDone) begin
				replyPending <= 1'b1;
			end else if (replyPending && !txBusy) begin
				replyPending <= 1'b0;
				txStart <= 1'b1;
			end
		end
	end

	assign txByte = replyByte;

	// a reply takes 10 bit times, a command 20, so never two queued
	decSingleReply: assert property (@(posedge clock) disable iff (!arstN)
		argDone |-> !replyPending);

endmodule

// ==== logic/linkRegs.sv ====
`timescale 1ns/1ps

module linkRegs
	import btLinkPkg::*;
(
	input logic clock,
	input logic arstN,
	input logic btState,
	input logic rxValid,
	input cmdEvent_t cmdEvt,
	input logic [15:0] ep01WireIn,
	input logic [15:0] ep02WireIn,
	output linkCfg_t cfg,
	output logic [15:0] cmdCount,
	output logic [15:0] ep20WireOut,
	output logic [15:0] ep21WireOut,
	output logic [15:0] ep22WireOut,
	output logic [15:0] ep23WireOut,
	output logic [15:0] ep24WireOut
);

	logic [15:0] rxCount;
	logic [15:0] errCount;
	logic [7:0] ledReg;
	logic [7:0] lastOp;
	logic [7:0] lastArg;
	logic knownOp;

	assign knownOp = (cmdEvt.opcode == opSetLed) || (cmdEvt.opcode == opEcho) ||
		(cmdEvt.opcode == opReadCmdCount);

	// host wire-ins, one cycle late
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			cfg.cyclesPerBit <= defaultCyclesPerBit;
			cfg.spacingLimit <= defaultSpacingLimit;
			cfg.clearCounts <= 1'b0;
		end else begin
			cfg.cyclesPerBit <= ep01WireIn;
			cfg.spacingLimit <= ep02WireIn[15:8];
			cfg.clearCounts <= ep02WireIn[0];
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			rxCount <= '0;
			cmdCount <= '0;
			errCount <= '0;
			ledReg <= '0;
			lastOp <= '0;
			lastArg <= '0;
		end else begin
			// bytes seen while the link is up
			if (rxValid && btState) begin
				rxCount <= rxCount + 16'd1;
			end
			if (cmdEvt.valid) begin
				lastOp <= cmdEvt.opcode;
				lastArg <= cmdEvt.arg;
				if (knownOp) begin
					cmdCount <= cmdCount + 16'd1;
				end else begin
					errCount <= errCount + 16'd1;
				end
				if (cmdEvt.opcode == opSetLed) begin
					ledReg <= cmdEvt.arg;
				end
			end
			// timeouts land in the error count too
			if (cmdEvt.timeout) begin
				errCount <= errCount + 16'd1;
			end
			// host clear wins over any update
			if (cfg.clearCounts) begin
				rxCount <= '0;
				cmdCount <= '0;
				errCount <= '0;
			end
		end
	end

	assign ep20WireOut = rxCount;
	assign ep21WireOut = cmdCount;
	assign ep22WireOut = {lastOp, lastArg};
	assign ep23WireOut = errCount;
	assign ep24WireOut = {8'h00, ledReg};

endmodule

// ==== logic/btLinkTop.sv ====
`timescale 1ns/1ps

module btLinkTop
	import btLinkPkg::*;
(
	input logic clock,
	input logic arstN,
	input logic btState,
	input logic fpgaRxd,
	output logic fpgaTxd,
	input logic [15:0] ep01WireIn,
	input logic [15:0] ep02WireIn,
	output logic [15:0] ep20WireOut,
	output logic [15:0] ep21WireOut,
	output logic [15:0] ep22WireOut,
	output logic [15:0] ep23WireOut,
	output logic [15:0] ep24WireOut
);

	linkCfg_t cfg;
	cmdEvent_t cmdEvt;
	logic [7:0] rxByte;
	logic rxValid;
	logic txStart;
	logic [7:0] txByte;
	logic txBusy;
	logic [15:0] cmdCount;

	// serial in from the bluetooth module
	uartRx i_uartRx (
		.clock(clock),
		.arstN(arstN),
		.rxd(fpgaRxd),
		.cfg(cfg),
		.rxByte(rxByte),
		.rxValid(rxValid)
	);

	// framing, timeout, replies
	cmdDecoder i_cmdDecoder (
		.clock(clock),
		.arstN(arstN),
		.cfg(cfg),
		.btState(btState),
		.rxByte(rxByte),
		.rxValid(rxValid),
		.txBusy(txBusy),
		.cmdCount(cmdCount),
		.cmdEvt(cmdEvt),
		.txStart(txStart),
		.txByte(txByte)
	);

	// reply byte back out
	uartTx i_uartTx (
		.clock(clock),
		.arstN(arstN),
		.cfg(cfg),
		.txStart(txStart),
		.txByte(txByte),
		.txd(fpgaTxd),
		.txBusy(txBusy)
	);

	// host config and status endpoints
	linkRegs i_linkRegs (
		.clock(clock),
		.arstN(arstN),
		.btState(btState),
		.rxValid(rxValid),
		.cmdEvt(cmdEvt),
		.ep01WireIn(ep01WireIn),
		.ep02WireIn(ep02WireIn),
		.cfg(cfg),
		.cmdCount(cmdCount),
		.ep20WireOut(ep20WireOut),
		.ep21WireOut(ep21WireOut),
		.ep22WireOut(ep22WireOut),
		.ep23WireOut(ep23WireOut),
		.ep24WireOut(ep24WireOut)
	);

endmodule

// ==== tb/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
	output logic clock,
	output logic arstN
);

	// 4 ns period
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// reset held for three cycles, released away from the rising edge
	initial begin
		arstN = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
	end

endmodule

// ==== tb/tbBtLink.sv ====
`timescale 1ns/1ps

module tbBtLink
	import btLinkPkg::*;
();

	localparam int clockPeriodNs = 4;
	localparam int batchSize = 40;
	// twice 200 commands of 40 bit times at the slowest bit time
	localparam int watchdogNs = 2 * 200 * 40 * 50 * clockPeriodNs;

	logic clock;
	logic arstN;
	logic btState;
	logic fpgaRxd;
	logic fpgaTxd;
	logic [15:0] ep01WireIn;
	logic [15:0] ep02WireIn;
	logic [15:0] ep20WireOut;
	logic [15:0] ep21WireOut;
	logic [15:0] ep22WireOut;
	logic [15:0] ep23WireOut;
	logic [15:0] ep24WireOut;

	integer seed;
	// clocks per bit as set on ep01WireIn
	int cpb;
	logic [7:0] replyQ[$];
	logic [7:0] expQ[$];

	// reference model of the status registers
	logic [15:0] modRxCount;
	logic [15:0] modCmdCount;
	logic [15:0] modErrCount;
	logic [7:0] modLed;
	logic [7:0] modLastOp;
	logic [7:0] modLastArg;

	tbClock i_tbClock (
		.clock(clock),
		.arstN(arstN)
	);

	btLinkTop i_btLinkTop (
		.clock(clock),
		.arstN(arstN),
		.btState(btState),
		.fpgaRxd(fpgaRxd),
		.fpgaTxd(fpgaTxd),
		.ep01WireIn(ep01WireIn),
		.ep02WireIn(ep02WireIn),
		.ep20WireOut(ep20WireOut),
		.ep21WireOut(ep21WireOut),
		.ep22WireOut(ep22WireOut),
		.ep23WireOut(ep23WireOut),
		.ep24WireOut(ep24WireOut)
	);

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual) begin
			stopRun($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	// rx line held high for n bit times
	task automatic idleBits(input int n);
		fpgaRxd = 1'b1;
		repeat (n * cpb) @(negedge clock);
	endtask

	// start bit, data lsb first, one stop bit
	task automatic sendByte(input logic [7:0] value, input int gapBits);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		idleBits(gapBits);
		for (int i = 0; i < 10; i++) begin
			fpgaRxd = frame[i];
			repeat (cpb) @(negedge clock);
		end
	endtask

	// opcode rule with the count taken before this command
	task automatic modelCommand(input logic [7:0] op, input logic [7:0] arg);
		logic [7:0] reply;
		modRxCount = modRxCount + 16'd2;
		modLastOp = op;
		modLastArg = arg;
		if (op == opSetLed) begin
			modLed = arg;
			reply = arg;
			modCmdCount = modCmdCount + 16'd1;
		end else if (op == opEcho) begin
			reply = arg;
			modCmdCount = modCmdCount + 16'd1;
		end else if (op == opReadCmdCount) begin
			reply = modCmdCount[7:0];
			modCmdCount = modCmdCount + 16'd1;
		end else begin
			reply = replyError;
			modErrCount = modErrCount + 16'd1;
		end
		expQ.push_back(reply);
	endtask

	task automatic waitReply(input string name);
		int waited;
		logic [7:0] gotByte;
		logic [7:0] expByte;
		waited = 0;
		while (replyQ.size() == 0) begin
			@(negedge clock);
			waited++;
			if (waited > 30 * cpb) begin
				stopRun($sformatf("no reply byte arrived during %s", name));
			end
		end
		gotByte = replyQ.pop_front();
		expByte = expQ.pop_front();
		check({name, " reply"}, {8'h00, expByte}, {8'h00, gotByte});
	endtask

	task automatic checkRegs(input string name);
		check({name, " ep20"}, modRxCount, ep20WireOut);
		check({name, " ep21"}, modCmdCount, ep21WireOut);
		check({name, " ep22"}, {modLastOp, modLastArg}, ep22WireOut);
		check({name, " ep23"}, modErrCount, ep23WireOut);
		check({name, " ep24"}, {8'h00, modLed}, ep24WireOut);
	endtask

	task automatic runCommand(input string name, input logic [7:0] op,
		input logic [7:0] arg, input int preBits, input int midBits);
		sendByte(op, preBits);
		sendByte(arg, midBits);
		modelCommand(op, arg);
		waitReply(name);
		checkRegs(name);
	endtask

	// known opcodes three times in four and any byte otherwise
	task automatic randomBatch(input string name, input int count);
		int r;
		int preBits;
		int midBits;
		logic [7:0] op;
		for (int n = 0; n < count; n++) begin
			r = $random(seed);
			case (r & 3)
				0: op = opSetLed;
				1: op = opEcho;
				2: op = opReadCmdCount;
				default: op = 8'((r >>> 8) & 255);
			endcase
			preBits = (r >>> 24) & 7;
			// arg gap of 0 to 2 bits keeps inside the 12 bit limit
			midBits = ((r >>> 28) & 1) + ((r >>> 29) & 1);
			runCommand(name, op, 8'((r >>> 16) & 255), preBits, midBits);
		end
	endtask

	// decodes fpgaTxd into replyQ
	initial begin : replySampler
		logic [7:0] shiftIn;
		forever begin
			@(negedge clock);
			if (arstN === 1'b1 && fpgaTxd === 1'b0) begin
				repeat (cpb / 2) @(negedge clock);
				if (fpgaTxd !== 1'b0) begin
					stopRun("reply start bit did not stay low");
				end
				for (int i = 0; i < 8; i++) begin
					repeat (cpb) @(negedge clock);
					shiftIn[i] = fpgaTxd;
				end
				repeat (cpb) @(negedge clock);
				if (fpgaTxd !== 1'b1) begin
					stopRun("reply stop bit was not high");
				end
				replyQ.push_back(shiftIn);
			end
		end
	end

	initial begin : watchdog
		#(watchdogNs);
		stopRun("watchdog expired before the tests finished");
	end

	initial begin : mainSequence
		seed = 90733;
		cpb = 50;
		btState = 1'b1;
		fpgaRxd = 1'b1;
		ep01WireIn = 16'd50;
		ep02WireIn = {8'd12, 8'd0};
		modRxCount = '0;
		modCmdCount = '0;
		modErrCount = '0;
		modLed = '0;
		modLastOp = '0;
		modLastArg = '0;
		@(posedge arstN);
		repeat (2) @(negedge clock);

		// defaults after reset with the tx line idle
		checkRegs("defaults");
		for (int i = 0; i < 3 * cpb; i++) begin
			@(negedge clock);
			check("defaults txd idle", 16'h0001, {15'h0000, fpgaTxd});
		end
		check("defaults no reply", 16'd0, 16'(replyQ.size()));

		randomBatch("random cpb50", batchSize);

		// lone opcode then silence past the limit
		sendByte(opEcho, 2);
		idleBits(20);
		modRxCount = modRxCount + 16'd1;
		modErrCount = modErrCount + 16'd1;
		check("timeout ep23", modErrCount, ep23WireOut);
		check("timeout no reply", 16'd0, 16'(replyQ.size()));
		runCommand("timeout fresh", opEcho, 8'h5A, 0, 1);
		// room for a stray second reply to show up
		idleBits(12);
		check("timeout single reply", 16'd0, 16'(replyQ.size()));

		// link down hides every byte
		idleBits(2);
		btState = 1'b0;
		sendByte(opSetLed, 1);
		sendByte(8'hFF, 0);
		sendByte(opEcho, 3);
		sendByte(8'h33, 1);
		idleBits(15);
		check("link down no reply", 16'd0, 16'(replyQ.size()));
		checkRegs("link down");
		btState = 1'b1;
		randomBatch("link up again", 5);

		// bit time change only while both lines idle
		idleBits(2);
		ep01WireIn = 16'd8;
		cpb = 8;
		idleBits(2);
		randomBatch("random cpb8", batchSize);
		idleBits(2);
		ep01WireIn = 16'd12;
		cpb = 12;
		idleBits(2);
		randomBatch("random cpb12", batchSize);
		idleBits(2);

		// host clear pulse keeps led and last command
		ep02WireIn[0] = 1'b1;
		repeat (3) @(negedge clock);
		ep02WireIn[0] = 1'b0;
		repeat (3) @(negedge clock);
		modRxCount = '0;
		modCmdCount = '0;
		modErrCount = '0;
		checkRegs("counter clear");

		$display("All checks passed");
		$finish;
	end

endmodule

// ==== tb.f ====
logic/btLinkPkg.sv
logic/uartRx.sv
logic/uartTx.sv
logic/cmdDecoder.sv
logic/linkRegs.sv
logic/btLinkTop.sv
tb/tbClock.sv
tb/tbBtLink.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := tbBtLink
FILELIST := tb.f
BUILD_DIR := obj_dir
PASS_MSG := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
